// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_riscv_ex
FILELIST  ?= vlog.f
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: riscv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_alu (
    input  riscv_pkg::alu_opt_t        alu_opt,
    input  logic [riscv_pkg::xlen-1:0] a,
    input  logic [riscv_pkg::xlen-1:0] b,
    output logic [riscv_pkg::xlen-1:0] y
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (alu_opt)
            riscv_pkg::alu_sub,
            riscv_pkg::alu_subu: y = a - b;        // branch kind only differs in compare
            riscv_pkg::alu_sll:  y = a << shamt;
            riscv_pkg::alu_slt:  y = {31'b0, $signed(a) < $signed(b)};
            riscv_pkg::alu_sltu: y = {31'b0, a < b};
            riscv_pkg::alu_xor:  y = a ^ b;
            riscv_pkg::alu_srl:  y = a >> shamt;
            riscv_pkg::alu_sra:  y = $signed(a) >>> shamt;
            riscv_pkg::alu_or:   y = a | b;
            riscv_pkg::alu_and:  y = a & b;
            default:             y = a + b;        // add and spare codes
        endcase
    end

endmodule

`default_nettype wire

// File: riscv_ex_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_ex_assertions #(
    parameter int OUT_CREDITS = 2
) (
    input logic clk,
    input logic arst_n,
    input logic in_valid,
    input logic in_credit,
    input logic res_valid,
    input logic res_credit
);

    logic [7:0] pending;    // accepted, credit not yet returned
    logic [7:0] out_held;   // output credits as seen from the ports

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending  <= '0;
            out_held <= 8'(OUT_CREDITS);
        end else begin
            pending  <= pending + 8'(in_valid) - 8'(in_credit);
            out_held <= out_held + 8'(res_credit) - 8'(res_valid);
        end
    end

    // issue one edge before res_valid, so a same-edge return is already counted
    a_res_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
        res_valid |-> out_held != 8'd0)
        else $error("result issued without an output credit");

    a_credit_after_accept: assert property (@(posedge clk) disable iff (!arst_n)
        in_credit |-> pending != 8'd0)
        else $error("input credit returned with nothing accepted");

    a_idle_after_reset: assert property (@(posedge clk)
        $rose(arst_n) |-> !res_valid && !in_credit)
        else $error("outputs active right after reset");

endmodule

bind riscv_ex_top riscv_ex_assertions #(.OUT_CREDITS(OUT_CREDITS)) i_assertions (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_credit  (in_credit),
    .res_valid  (res_valid),
    .res_credit (res_credit)
);

`default_nettype wire

// File: riscv_ex_top.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_ex_top #(
    parameter int IN_DEPTH    = 4,   // also the upstream credit count
    parameter int OUT_CREDITS = 2
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_valid,
    input  riscv_pkg::instr_t   in_instr,
    output logic                in_credit,
    output logic                res_valid,
    output riscv_pkg::result_t  res,
    input  logic                res_credit
);

    riscv_pkg::instr_t          head;
    riscv_pkg::dec_t            dec;
    logic                       not_empty;
    logic                       pop;
    logic [4:0]                 raddr1;
    logic [4:0]                 raddr2;
    logic [riscv_pkg::xlen-1:0] rdata1;
    logic [riscv_pkg::xlen-1:0] rdata2;
    logic [riscv_pkg::xlen-1:0] alu_a;
    logic [riscv_pkg::xlen-1:0] alu_b;
    logic [riscv_pkg::xlen-1:0] alu_y;
    logic                       we;
    logic [4:0]                 waddr;
    logic [riscv_pkg::xlen-1:0] wdata;

    riscv_instr_queue #(.DEPTH(IN_DEPTH)) i_queue (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (in_valid),
        .din       (in_instr),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .credit    (in_credit)
    );

    riscv_id i_id (
        .insn (head.insn),   // decodes the head combinationally
        .dec  (dec)
    );

    riscv_regfile i_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (we),
        .waddr  (waddr),
        .wdata  (wdata)
    );

    riscv_alu i_alu (
        .alu_opt (dec.alu_opt),
        .a       (alu_a),
        .b       (alu_b),
        .y       (alu_y)
    );

    riscv_exec #(.OUT_CREDITS(OUT_CREDITS)) i_exec (
        .clk        (clk),
        .arst_n     (arst_n),
        .not_empty  (not_empty),
        .head       (head),
        .dec        (dec),
        .pop        (pop),
        .raddr1     (raddr1),
        .raddr2     (raddr2),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_y      (alu_y),
        .we         (we),
        .waddr      (waddr),
        .wdata      (wdata),
        .res_credit (res_credit),
        .res_valid  (res_valid),
        .res        (res)
    );

endmodule

`default_nettype wire

// File: riscv_exec.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_exec #(
    parameter int OUT_CREDITS = 2
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       not_empty,
    input  riscv_pkg::instr_t          head,
    input  riscv_pkg::dec_t            dec,
    output logic                       pop,
    output logic [4:0]                 raddr1,
    output logic [4:0]                 raddr2,
    input  logic [riscv_pkg::xlen-1:0] rdata1,
    input  logic [riscv_pkg::xlen-1:0] rdata2,
    output logic [riscv_pkg::xlen-1:0] alu_a,
    output logic [riscv_pkg::xlen-1:0] alu_b,
    input  logic [riscv_pkg::xlen-1:0] alu_y,
    output logic                       we,
    output logic [4:0]                 waddr,
    output logic [riscv_pkg::xlen-1:0] wdata,
    input  logic                       res_credit,
    output logic                       res_valid,
    output riscv_pkg::result_t         res
);

    localparam int CW = $clog2(OUT_CREDITS + 1);

    logic [CW-1:0]              credits;   // held output credits
    logic                       issue;
    logic                       taken;
    logic [riscv_pkg::xlen-1:0] next_pc;
    riscv_pkg::result_t         res_d;

    // a credit returned this cycle can be spent right away
    assign issue = not_empty && (credits != '0 || res_credit);
    assign pop   = issue;

    assign raddr1 = dec.rs1;
    assign raddr2 = dec.rs2;
    assign we     = issue && dec.rd_we;   // lands at the pop edge
    assign waddr  = dec.rd;
    assign wdata  = alu_y;

    always_comb begin
        case (dec.src_sel)
            riscv_pkg::src_pc_imm: begin alu_a = head.pc; alu_b = dec.imm; end
            riscv_pkg::src_pc_4:   begin alu_a = head.pc; alu_b = 32'd4;   end
            riscv_pkg::src_rs1_2:  begin alu_a = rdata1;  alu_b = rdata2;  end
            default:               begin alu_a = rdata1;  alu_b = dec.imm; end
        endcase
        if (head.insn[6:0] == riscv_pkg::opc_lui) alu_a = '0;   // rd = imm
    end

    // eq from the alu difference, ordering from direct compares
    always_comb begin
        case (dec.funct3)
            3'b000:  taken = (alu_y == '0);
            3'b001:  taken = (alu_y != '0);
            3'b100:  taken = $signed(rdata1) <  $signed(rdata2);
            3'b101:  taken = $signed(rdata1) >= $signed(rdata2);
            3'b110:  taken = rdata1 <  rdata2;
            3'b111:  taken = rdata1 >= rdata2;
            default: taken = 1'b0;
        endcase
        if (dec.is_jal || (dec.is_branch && taken)) next_pc = head.pc + dec.imm;
        else if (dec.is_jalr)                       next_pc = (rdata1 + dec.imm) & ~32'd1;
        else                                        next_pc = head.pc + 32'd4;
    end

    always_comb begin
        res_d            = '0;
        res_d.pc         = head.pc;
        res_d.next_pc    = next_pc;
        res_d.rd         = dec.rd;
        res_d.rd_we      = dec.rd_we;
        res_d.wdata      = alu_y;
        res_d.lsu_opt    = dec.lsu_opt;
        res_d.mem_addr   = alu_y;    // rs1 + imm for load/store
        res_d.store_data = rdata2;
    end

    always_ff @(posedge clk) begin
        if (issue) res <= res_d;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits   <= CW'(OUT_CREDITS);
            res_valid <= 1'b0;
        end else begin
            credits   <= credits + CW'(res_credit) - CW'(issue);
            res_valid <= issue;   // one cycle per result
        end
    end

endmodule

`default_nettype wire

// File: riscv_id.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_id (
    input  logic [31:0]      insn,
    output riscv_pkg::dec_t  dec
);

    logic [6:0]          opcode;
    riscv_pkg::alu_opt_t alu_opt;
    riscv_pkg::src_sel_t src_sel;
    riscv_pkg::lsu_opt_t lsu_opt;

    assign opcode = insn[6:0];

    riscv_id_opt i_id_opt (
        .opcode  (opcode),
        .funct3  (insn[14:12]),
        .funct7  (insn[31:25]),
        .alu_opt (alu_opt),
        .src_sel (src_sel),
        .lsu_opt (lsu_opt)
    );

    always_comb begin
        dec         = '0;
        dec.rs1     = insn[19:15];
        dec.rs2     = insn[24:20];
        dec.rd      = insn[11:7];
        dec.funct3  = insn[14:12];
        dec.alu_opt = alu_opt;
        dec.src_sel = src_sel;
        dec.lsu_opt = lsu_opt;
        case (opcode)
            riscv_pkg::opc_lui, riscv_pkg::opc_auipc:
                dec.imm = {insn[31:12], 12'b0};                              // u
            riscv_pkg::opc_jal:
                dec.imm = {{11{insn[31]}}, insn[31], insn[19:12], insn[20],
                           insn[30:21], 1'b0};                               // j
            riscv_pkg::opc_branch:
                dec.imm = {{19{insn[31]}}, insn[31], insn[7], insn[30:25],
                           insn[11:8], 1'b0};                                // b
            riscv_pkg::opc_store:
                dec.imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};         // s
            default:
                dec.imm = {{20{insn[31]}}, insn[31:20]};                     // i, shamt in [4:0]
        endcase
        dec.is_branch = (opcode == riscv_pkg::opc_branch);
        dec.is_jal    = (opcode == riscv_pkg::opc_jal);
        dec.is_jalr   = (opcode == riscv_pkg::opc_jalr);
        // loads stay off, no data memory here
        dec.rd_we = (opcode == riscv_pkg::opc_lui)    || (opcode == riscv_pkg::opc_auipc)
                 || (opcode == riscv_pkg::opc_jal)    || (opcode == riscv_pkg::opc_jalr)
                 || (opcode == riscv_pkg::opc_op_imm) || (opcode == riscv_pkg::opc_op);
    end

endmodule

`default_nettype wire

// File: riscv_id_opt.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_id_opt (
    input  logic [6:0]           opcode,
    input  logic [2:0]           funct3,
    input  logic [6:0]           funct7,
    output riscv_pkg::alu_opt_t  alu_opt,
    output riscv_pkg::src_sel_t  src_sel,
    output riscv_pkg::lsu_opt_t  lsu_opt
);

    always_comb begin
        alu_opt = riscv_pkg::alu_add;
        case (opcode)
            riscv_pkg::opc_branch: begin
                // bltu/bgeu compare unsigned
                if (funct3[2:1] == 2'b11) alu_opt = riscv_pkg::alu_subu;
                else                      alu_opt = riscv_pkg::alu_sub;
            end
            riscv_pkg::opc_op_imm, riscv_pkg::opc_op: begin
                case (funct3)
                    3'b000: begin
                        // only op has sub, addi ignores imm bits
                        if (opcode == riscv_pkg::opc_op && funct7 == 7'b010_0000)
                            alu_opt = riscv_pkg::alu_sub;
                        else
                            alu_opt = riscv_pkg::alu_add;
                    end
                    3'b001: alu_opt = riscv_pkg::alu_sll;
                    3'b010: alu_opt = riscv_pkg::alu_slt;    // slt, slti
                    3'b011: alu_opt = riscv_pkg::alu_sltu;
                    3'b100: alu_opt = riscv_pkg::alu_xor;
                    3'b101: begin
                        case (funct7)
                            7'b000_0000: alu_opt = riscv_pkg::alu_srl;
                            7'b010_0000: alu_opt = riscv_pkg::alu_sra;
                            default:     alu_opt = riscv_pkg::alu_add;   // unknown funct7
                        endcase
                    end
                    3'b110: alu_opt = riscv_pkg::alu_or;
                    default: alu_opt = riscv_pkg::alu_and;
                endcase
            end
            riscv_pkg::opc_fence, riscv_pkg::opc_sys: alu_opt = riscv_pkg::alu_and;  // no-ops
            default: alu_opt = riscv_pkg::alu_add;    // lui auipc jal jalr load store
        endcase
    end

    riscv_mux #(
        .NR_KEY   (11),
        .KEY_LEN  (7),
        .DATA_LEN ($bits(riscv_pkg::src_sel_t))
    ) i_mux_src_sel (
        .key         (opcode),
        .default_out (riscv_pkg::src_rs1_imm),
        .lut         ({riscv_pkg::opc_lui,    riscv_pkg::src_rs1_imm,   // a forced to 0 later
                       riscv_pkg::opc_auipc,  riscv_pkg::src_pc_imm,
                       riscv_pkg::opc_jal,    riscv_pkg::src_pc_4,      // link value
                       riscv_pkg::opc_jalr,   riscv_pkg::src_pc_4,
                       riscv_pkg::opc_branch, riscv_pkg::src_rs1_2,
                       riscv_pkg::opc_load,   riscv_pkg::src_rs1_imm,
                       riscv_pkg::opc_store,  riscv_pkg::src_rs1_imm,
                       riscv_pkg::opc_op_imm, riscv_pkg::src_rs1_imm,
                       riscv_pkg::opc_op,     riscv_pkg::src_rs1_2,
                       riscv_pkg::opc_fence,  riscv_pkg::src_rs1_imm,
                       riscv_pkg::opc_sys,    riscv_pkg::src_rs1_imm}),
        .out         (src_sel)
    );

    riscv_mux #(
        .NR_KEY   (2),
        .KEY_LEN  (7),
        .DATA_LEN ($bits(riscv_pkg::lsu_opt_t))
    ) i_mux_lsu_opt (
        .key         (opcode),
        .default_out (riscv_pkg::lsu_none),
        .lut         ({riscv_pkg::opc_load,  riscv_pkg::lsu_load,
                       riscv_pkg::opc_store, riscv_pkg::lsu_store}),
        .out         (lsu_opt)
    );

endmodule

`default_nettype wire

// File: riscv_instr_queue.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_instr_queue #(
    parameter int DEPTH = 4
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               push,
    input  riscv_pkg::instr_t  din,
    input  logic               pop,
    output riscv_pkg::instr_t  head,
    output logic               not_empty,
    output logic               credit      // one pulse per popped entry
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    riscv_pkg::instr_t mem [DEPTH];
    logic [PW-1:0]     wr_ptr;
    logic [PW-1:0]     rd_ptr;
    logic [CW-1:0]     count;

    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);

    // payload only, written on push
    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= din;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)  rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count  <= count + CW'(push) - CW'(pop);   // producer holds credits, no overflow
            credit <= pop;
        end
    end

endmodule

`default_nettype wire

// File: riscv_mux.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_mux #(
    parameter int NR_KEY   = 2,
    parameter int KEY_LEN  = 7,
    parameter int DATA_LEN = 2
) (
    input  logic [KEY_LEN-1:0]                   key,
    input  logic [DATA_LEN-1:0]                  default_out,
    input  logic [NR_KEY*(KEY_LEN+DATA_LEN)-1:0] lut,   // {key, value} pairs, first at msb
    output logic [DATA_LEN-1:0]                  out
);

    localparam int PAIR_LEN = KEY_LEN + DATA_LEN;

    // scan from the lsb pair up, so the first listed match is written last and wins
    always_comb begin
        out = default_out;
        for (int i = 0; i < NR_KEY; i++) begin
            if (lut[i*PAIR_LEN+DATA_LEN +: KEY_LEN] == key) begin
                out = lut[i*PAIR_LEN +: DATA_LEN];
            end
        end
    end

endmodule

`default_nettype wire

// File: riscv_pkg.sv
`default_nettype none

package riscv_pkg;

    localparam int xlen = 32;

    // major opcodes, insn[6:0]
    localparam logic [6:0] opc_lui    = 7'b011_0111;
    localparam logic [6:0] opc_auipc  = 7'b001_0111;
    localparam logic [6:0] opc_jal    = 7'b110_1111;
    localparam logic [6:0] opc_jalr   = 7'b110_0111;
    localparam logic [6:0] opc_branch = 7'b110_0011;
    localparam logic [6:0] opc_load   = 7'b000_0011;
    localparam logic [6:0] opc_store  = 7'b010_0011;
    localparam logic [6:0] opc_op_imm = 7'b001_0011;
    localparam logic [6:0] opc_op     = 7'b011_0011;
    localparam logic [6:0] opc_fence  = 7'b000_1111;
    localparam logic [6:0] opc_sys    = 7'b111_0011;

    typedef logic [3:0] alu_opt_t;
    localparam alu_opt_t alu_add  = 4'd0;   // also the fallback
    localparam alu_opt_t alu_sub  = 4'd1;
    localparam alu_opt_t alu_subu = 4'd2;
    localparam alu_opt_t alu_sll  = 4'd3;
    localparam alu_opt_t alu_slt  = 4'd4;
    localparam alu_opt_t alu_sltu = 4'd5;
    localparam alu_opt_t alu_xor  = 4'd6;
    localparam alu_opt_t alu_srl  = 4'd7;
    localparam alu_opt_t alu_sra  = 4'd8;
    localparam alu_opt_t alu_or   = 4'd9;
    localparam alu_opt_t alu_and  = 4'd10;

    // operand pairs a/b
    typedef logic [1:0] src_sel_t;
    localparam src_sel_t src_rs1_imm = 2'd0;
    localparam src_sel_t src_pc_imm  = 2'd1;
    localparam src_sel_t src_pc_4    = 2'd2;
    localparam src_sel_t src_rs1_2   = 2'd3;

    typedef logic [1:0] lsu_opt_t;
    localparam lsu_opt_t lsu_none  = 2'd0;
    localparam lsu_opt_t lsu_load  = 2'd1;
    localparam lsu_opt_t lsu_store = 2'd2;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [31:0]     insn;
    } instr_t;

    typedef struct packed {
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic [xlen-1:0] imm;       // sign extended, format by opcode
        alu_opt_t        alu_opt;
        src_sel_t        src_sel;
        lsu_opt_t        lsu_opt;
        logic [2:0]      funct3;    // branch condition select
        logic            is_branch;
        logic            is_jal;
        logic            is_jalr;
        logic            rd_we;
    } dec_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] next_pc;
        logic [4:0]      rd;
        logic            rd_we;
        logic [xlen-1:0] wdata;
        lsu_opt_t        lsu_opt;
        logic [xlen-1:0] mem_addr;
        logic [xlen-1:0] store_data;
    } result_t;

endpackage

`default_nettype wire

// File: riscv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_regfile (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [4:0]                 raddr1,
    input  logic [4:0]                 raddr2,
    output logic [riscv_pkg::xlen-1:0] rdata1,
    output logic [riscv_pkg::xlen-1:0] rdata2,
    input  logic                       we,
    input  logic [4:0]                 waddr,
    input  logic [riscv_pkg::xlen-1:0] wdata
);

    logic [riscv_pkg::xlen-1:0] regs [32];

    // async read, no bypass needed since write-back and read share one cycle
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin   // x0 stays zero
            regs[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

// File: tb_riscv_ex.sv
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_ex;

    localparam int IN_DEPTH    = 4;
    localparam int OUT_CREDITS = 2;
    localparam int N_MIX       = 150;   // free-flowing credits
    localparam int N_HOLD      = 150;   // consumer withholds credits in bursts
    localparam int N_LAT       = 4;     // single-issue latency probes
    localparam int CYCLE_LIMIT = 20 * (N_MIX + N_HOLD + N_LAT);

    logic               clk;
    logic               arst_n;
    logic               in_valid;
    riscv_pkg::instr_t  in_instr;
    logic               in_credit;
    logic               res_valid;
    riscv_pkg::result_t res;
    logic               res_credit;

    logic [31:0]        rng_state;
    logic [31:0]        regs_m [32];   // reference register file
    riscv_pkg::instr_t  model_q [$];   // sent, not yet retired
    int                 in_credits;    // producer side
    int                 owed;          // credits the consumer still has to return
    int                 sent;
    int                 send_limit;
    int                 credit_pulses;
    int                 errors;
    int                 cycles;
    int                 err_mark;
    int                 lat;
    int                 hold_pct;
    int                 burst_cyc;     // steps into the hold test

    riscv_ex_top #(.IN_DEPTH(IN_DEPTH), .OUT_CREDITS(OUT_CREDITS)) i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_instr   (in_instr),
        .in_credit  (in_credit),
        .res_valid  (res_valid),
        .res        (res),
        .res_credit (res_credit)
    );

    always #50 clk = ~clk;

    // run limit, scaled to the instruction count
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: DUT stopped producing results after %0d cycles", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                            logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // legal instruction of a random class, registers mostly x0..x7
    function automatic logic [31:0] gen_insn();
        logic [31:0] r;
        logic [31:0] s;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r   = xorshift32();
        s   = xorshift32();
        rd  = {2'b0, s[2:0]};
        rs1 = {2'b0, s[5:3]};
        rs2 = {2'b0, s[8:6]};
        f3  = s[11:9];
        f7  = s[12] ? 7'b010_0000 : 7'b000_0000;
        case (s[31:16] % 10)
            0: return {r[31:12], rd, riscv_pkg::opc_lui};
            1: return {r[31:12], rd, riscv_pkg::opc_auipc};
            2: return {r[31:12], rd, riscv_pkg::opc_jal};
            3: return {r[31:20], rs1, 3'b000, rd, riscv_pkg::opc_jalr};
            4: begin
                if (f3[2:1] == 2'b01) f3 = f3 ^ 3'b110;   // no 010/011 branches
                return {r[31:25], rs2, rs1, f3, r[11:7], riscv_pkg::opc_branch};
            end
            5: begin
                if (f3 == 3'd3 || f3[2:1] == 2'b11) f3 = f3 & 3'b101;   // lb lh lw lbu lhu
                return {r[31:20], rs1, f3, rd, riscv_pkg::opc_load};
            end
            6: return {r[31:25], rs2, rs1, 3'(f3 % 3), r[11:7], riscv_pkg::opc_store};
            7: begin
                if (f3 == 3'd1) return {7'b0, r[24:20], rs1, f3, rd, riscv_pkg::opc_op_imm};
                if (f3 == 3'd5) return {f7, r[24:20], rs1, f3, rd, riscv_pkg::opc_op_imm};
                return {r[31:20], rs1, f3, rd, riscv_pkg::opc_op_imm};
            end
            8: begin
                if (f3 != 3'd0 && f3 != 3'd5) f7 = 7'b0;
                return {f7, rs2, rs1, f3, rd, riscv_pkg::opc_op};
            end
            default: return {r[31:20], rs1, 3'b000, rd,
                             s[13] ? riscv_pkg::opc_fence : riscv_pkg::opc_sys};
        endcase
    endfunction

    function automatic riscv_pkg::result_t model_exec(riscv_pkg::instr_t ins);
        riscv_pkg::result_t r;
        logic [31:0] i;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [2:0]  f3;
        logic        taken;
        i     = ins.insn;
        f3    = i[14:12];
        a     = regs_m[i[19:15]];
        b     = regs_m[i[24:20]];
        imm_i = {{20{i[31]}}, i[31:20]};
        r            = '0;
        r.pc         = ins.pc;
        r.next_pc    = ins.pc + 32'd4;
        r.rd         = i[11:7];
        r.store_data = b;
        case (i[6:0])
            riscv_pkg::opc_lui: begin
                r.wdata = {i[31:12], 12'b0};
                r.rd_we = 1'b1;
            end
            riscv_pkg::opc_auipc: begin
                r.wdata = ins.pc + {i[31:12], 12'b0};
                r.rd_we = 1'b1;
            end
            riscv_pkg::opc_jal: begin
                r.wdata   = ins.pc + 32'd4;
                r.rd_we   = 1'b1;
                r.next_pc = ins.pc + {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
            end
            riscv_pkg::opc_jalr: begin
                r.wdata   = ins.pc + 32'd4;
                r.rd_we   = 1'b1;
                r.next_pc = (a + imm_i) & ~32'd1;
            end
            riscv_pkg::opc_branch: begin
                r.wdata = a - b;
                case (f3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = $signed(a) < $signed(b);
                    3'd5:    taken = $signed(a) >= $signed(b);
                    3'd6:    taken = a < b;
                    default: taken = a >= b;
                endcase
                if (taken) r.next_pc = ins.pc + {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
            end
            riscv_pkg::opc_load: begin
                r.wdata   = a + imm_i;
                r.lsu_opt = riscv_pkg::lsu_load;
            end
            riscv_pkg::opc_store: begin
                r.wdata   = a + {{20{i[31]}}, i[31:25], i[11:7]};
                r.lsu_opt = riscv_pkg::lsu_store;
            end
            riscv_pkg::opc_op_imm: begin
                r.wdata = alu_ref(f3, f3 == 3'd5 && i[30], a, imm_i);
                r.rd_we = 1'b1;
            end
            riscv_pkg::opc_op: begin
                r.wdata = alu_ref(f3, (f3 == 3'd0 || f3 == 3'd5) && i[30], a, b);
                r.rd_we = 1'b1;
            end
            default: r.wdata = a & imm_i;   // fence, system: and with rs1/imm
        endcase
        r.mem_addr = r.wdata;
        return r;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] res.%s: expected %h, got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_result();
        riscv_pkg::result_t exp;
        assert (model_q.size() != 0) else begin
            $display("result arrived with no instruction outstanding");
            errors++;
        end
        if (model_q.size() != 0) begin
            exp = model_exec(model_q.pop_front());
            compare("pc", res.pc, exp.pc);
            compare("next_pc", res.next_pc, exp.next_pc);
            compare("rd", 32'(res.rd), 32'(exp.rd));
            compare("rd_we", 32'(res.rd_we), 32'(exp.rd_we));
            compare("wdata", res.wdata, exp.wdata);
            compare("lsu_opt", 32'(res.lsu_opt), 32'(exp.lsu_opt));
            compare("mem_addr", res.mem_addr, exp.mem_addr);
            compare("store_data", res.store_data, exp.store_data);
            if (exp.rd_we && exp.rd != 5'd0) regs_m[exp.rd] = exp.wdata;   // x0 stays zero
        end
    endtask

    // one clock: collect outputs, return credits, maybe send
    task automatic step(input int send_pct, input int credit_pct);
        riscv_pkg::instr_t ins;
        @(posedge clk);
        if (in_credit) begin
            in_credits++;
            credit_pulses++;
        end
        if (res_valid) begin
            check_result();
            owed++;
        end
        res_credit <= 1'b0;
        if (owed > 0 && (xorshift32() % 100) < credit_pct) begin
            res_credit <= 1'b1;
            owed--;
        end
        in_valid <= 1'b0;
        if (sent < send_limit && in_credits > 0 && (xorshift32() % 100) < send_pct) begin
            ins.pc   = xorshift32() & ~32'd3;
            ins.insn = gen_insn();
            model_q.push_back(ins);
            in_valid <= 1'b1;
            in_instr <= ins;
            in_credits--;
            sent++;
        end
    endtask

    task automatic drain();
        while (model_q.size() != 0 || owed != 0) step(0, 100);
        repeat (4) step(0, 100);
    endtask

    initial begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        in_instr   = '0;
        res_credit = 1'b0;
        rng_state  = 32'hb1a2;
        in_credits = IN_DEPTH;
        owed = 0;
        sent = 0;
        send_limit = 0;
        credit_pulses = 0;
        errors = 0;
        cycles = 0;
        for (int r = 0; r < 32; r++) regs_m[r] = '0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        err_mark   = errors;
        send_limit = N_MIX;
        while (sent < send_limit) step(80, 90);
        drain();
        $display("test random mix: %0d instructions, %0d errors", N_MIX, errors - err_mark);

        err_mark   = errors;
        send_limit = sent + N_HOLD;
        hold_pct   = 0;
        burst_cyc  = 0;
        while (sent < send_limit) begin
            if ((burst_cyc % 16) == 0) hold_pct = (hold_pct == 0) ? 60 : 0;   // credit bursts
            step(90, hold_pct);
            burst_cyc++;
        end
        drain();
        assert (credit_pulses == sent) else begin
            $display("[ERROR] in_credit pulses: expected %h, got %h", sent, credit_pulses);
            errors++;
        end
        $display("test credit hold: %0d instructions, %0d errors", N_HOLD, errors - err_mark);

        err_mark = errors;
        repeat (N_LAT) begin
            send_limit = sent + 1;
            step(100, 100);
            lat = 0;
            while (model_q.size() != 0) begin
                step(0, 100);
                lat++;
            end
            // accepted at the next edge, result seen two edges after that
            assert (lat == 3) else begin
                $display("[ERROR] res_valid latency: expected %h, got %h", 3, lat);
                errors++;
            end
            drain();
        end
        $display("test issue latency: %0d probes, %0d errors", N_LAT, errors - err_mark);

        $display("sent %0d, credits back %0d, errors %0d", sent, credit_pulses, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
riscv_pkg.sv
riscv_mux.sv
riscv_id_opt.sv
riscv_id.sv
riscv_regfile.sv
riscv_alu.sv
riscv_instr_queue.sv
riscv_exec.sv
riscv_ex_top.sv
riscv_ex_assertions.sv
tb_riscv_ex.sv
